// File: hdl/byte_bank.sv
`timescale 1ns/1ps

module byte_bank (
    input  logic clk,
    lane_if.bank lane
);
    import mem_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [7:0] mem [row_count];                       // one byte of every word.

    // two read ports and one write port, all on the same edge.
    // nonblocking reads see the byte before the write lands.
    always_ff @(posedge clk) begin
        if (lane.we) begin
            mem[lane.d_row] <= lane.wbyte;             // store at its own edge.
        end
        lane.d_byte <= mem[lane.d_row];                // data read, old byte on collision.
        lane.i_byte <= mem[lane.i_row];                // fetch read.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // an unknown row from the splitter would corrupt a random byte.
    a_we_row_known: assert property (
        @(posedge clk)
        lane.we |-> !$isunknown(lane.d_row)
    ) else $error("byte_bank: write strobe with unknown row %0h", lane.d_row);

endmodule

// File: hdl/lane_if.sv
`timescale 1ns/1ps

interface lane_if;
    import mem_pkg::*;

    // addressing, from the splitter.
    logic [row_bits-1:0] i_row;                        // fetch row, same on every lane.
    logic [row_bits-1:0] d_row;                        // data row, base or base+1.
    logic                we;                           // byte write strobe.
    logic [7:0]          wbyte;                        // rotated store byte.

    // read data, from the bank.
    logic [7:0]          i_byte;                       // registered fetch byte.
    logic [7:0]          d_byte;                       // registered data byte.

    modport splitter (
        output i_row, d_row, we, wbyte
    );

    modport bank (
        input  i_row, d_row, we, wbyte,
        output i_byte, d_byte
    );

    modport merger (
        input i_byte, d_byte
    );

endinterface

// File: hdl/load_merger.sv
`timescale 1ns/1ps

module load_merger (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [mem_pkg::word_len-1:0] d_addr,
    input  mem_pkg::mem_op_e             d_op,
    lane_if.merger                       lanes [mem_pkg::lane_count],
    output logic [mem_pkg::word_len-1:0] rdata,
    output logic [mem_pkg::word_len-1:0] inst
);
    import mem_pkg::*;

    mem_op_e              op_q;                        // opcode of the read in flight.
    logic [lane_bits-1:0] off_q;                       // its byte offset.
    logic                 load_q;                      // bank bytes belong to a load.
    logic                 fetch_live;                  // banks have been read once.
    logic [word_len-1:0]  rdata_q;                     // last load result, held.
    logic [7:0]           d_lane [lane_count];         // data bytes by lane.
    logic [word_len-1:0]  gathered;                    // bytes back in address order.
    logic [word_len-1:0]  loaded;                      // after extension.
    logic [word_len-1:0]  fetched;                     // fetch word in lane order.

    for (genvar g = 0; g < lane_count; g++) begin : g_lane
        assign d_lane[g]           = lanes[g].d_byte;
        assign fetched[8*g +: 8]   = lanes[g].i_byte;  // aligned, no rotation.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // second cycle state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q       <= op_none;
            off_q      <= '0;
            load_q     <= 1'b0;
            fetch_live <= 1'b0;
            rdata_q    <= '0;
        end else begin
            op_q       <= d_op;                        // same edge the banks sample.
            off_q      <= d_addr[lane_bits-1:0];
            load_q     <= is_load(d_op);               // stores and idle clear it.
            fetch_live <= 1'b1;
            if (load_q) begin
                rdata_q <= loaded;                     // keep it for later idle cycles.
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rotate and extend
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int k = 0; k < lane_count; k++) begin
            gathered[8*k +: 8] = d_lane[lane_bits'(off_q + lane_bits'(k))]; // byte k of access.
        end
    end

    always_comb begin
        case (op_q)
            op_lb:   loaded = {{(word_len-8){gathered[7]}}, gathered[7:0]};
            op_lbu:  loaded = {{(word_len-8){1'b0}}, gathered[7:0]};
            op_lh:   loaded = {{(word_len-16){gathered[15]}}, gathered[15:0]};
            op_lhu:  loaded = {{(word_len-16){1'b0}}, gathered[15:0]};
            default: loaded = gathered;                // lw passes the whole word.
        endcase
    end

    assign rdata = load_q ? loaded : rdata_q;          // holds through stores and idle.
    assign inst  = fetch_live ? fetched : '0;          // zero until the first read.

    // a store or idle cycle must not disturb the load result seen by the core.
    a_rdata_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        !is_load(d_op) |=> $stable(rdata)
    ) else $error("load_merger: rdata moved after a non-load cycle");

endmodule

// File: hdl/mem_pkg.sv
package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int word_len  = 32;                     // address and data word width.
    localparam int mem_bytes = 16384;                  // total memory in bytes.
    localparam int lane_count = 4;                     // one lane per byte of a word.
    localparam int lane_bits = $clog2(lane_count);     // byte offset inside a row.
    localparam int row_count = mem_bytes / lane_count; // rows held by each lane.
    localparam int row_bits  = $clog2(row_count);      // row index width, 12.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data port opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [7:0] {
        op_none = 8'h00,                               // idle cycle.
        op_lb   = 8'h01,                               // load byte, sign extended.
        op_lh   = 8'h02,                               // load halfword, sign extended.
        op_lw   = 8'h03,                               // load word.
        op_lbu  = 8'h04,                               // load byte, zero extended.
        op_lhu  = 8'h05,                               // load halfword, zero extended.
        op_sb   = 8'h11,                               // store byte.
        op_sh   = 8'h12,                               // store halfword.
        op_sw   = 8'h13                                // store word.
    } mem_op_e;

    // true for the five load opcodes.
    function automatic logic is_load(mem_op_e op);
        logic hit;
        case (op)
            op_lb, op_lh, op_lw, op_lbu, op_lhu: hit = 1'b1;
            default:                             hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage

// File: hdl/store_splitter.sv
`timescale 1ns/1ps

module store_splitter (
    input  logic                         clk,
    input  logic [mem_pkg::word_len-1:0] i_addr,
    input  logic [mem_pkg::word_len-1:0] d_addr,
    input  mem_pkg::mem_op_e             d_op,
    input  logic [mem_pkg::word_len-1:0] wdata,
    lane_if.splitter                     lanes [mem_pkg::lane_count]
);
    import mem_pkg::*;

    logic [lane_bits-1:0] offset;                      // first lane touched.
    logic [row_bits-1:0]  base;                        // row of the first byte.
    logic [row_bits-1:0]  base_next;                   // row the access spills into.
    logic [row_bits-1:0]  fetch_row;                   // word row of the fetch.
    logic [2:0]           store_len;                   // bytes written, 0 when not a store.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address split
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign offset    = d_addr[lane_bits-1:0];          // byte within the row.
    assign base      = d_addr[lane_bits +: row_bits];  // upper bits drop, so it wraps.
    assign base_next = base + 1'b1;                    // last row rolls over to row 0.
    assign fetch_row = i_addr[lane_bits +: row_bits];  // fetch is word aligned.

    always_comb begin
        case (d_op)
            op_sb:   store_len = 3'd1;                 // one byte.
            op_sh:   store_len = 3'd2;                 // two bytes.
            op_sw:   store_len = 3'd4;                 // full word.
            default: store_len = 3'd0;                 // loads and idle write nothing.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per lane row, strobe and byte
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar g = 0; g < lane_count; g++) begin : g_lane
        logic [lane_bits-1:0] k;                       // which wdata byte lands here.

        assign k = lane_bits'(g) - offset;             // mod 4 by width.

        assign lanes[g].i_row = fetch_row;
        // lanes below the offset hold the spilled bytes one row up.
        assign lanes[g].d_row = (lane_bits'(g) >= offset) ? base : base_next;
        assign lanes[g].we    = ({1'b0, k} < store_len); // only the n addressed lanes.
        assign lanes[g].wbyte = wdata[8*k +: 8];       // little endian rotation.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a stray encoding would silently act as idle.
    a_op_known: assert property (
        @(posedge clk)
        d_op inside {op_none, op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw}
    ) else $error("store_splitter: d_op %0h is not a known opcode", d_op);

    // fetch has no rotation path, the low bits are dropped.
    a_fetch_aligned: assert property (
        @(posedge clk)
        i_addr[lane_bits-1:0] == '0
    ) else $error("store_splitter: i_addr %0h is not word aligned", i_addr);

endmodule

// File: hdl/unified_mem.sv
`timescale 1ns/1ps

module unified_mem (
    input  logic                         clk,
    input  logic                         rst_n,
    // instruction fetch port.
    input  logic [mem_pkg::word_len-1:0] i_addr,
    output logic [mem_pkg::word_len-1:0] inst,
    // data port.
    input  logic [mem_pkg::word_len-1:0] d_addr,
    input  mem_pkg::mem_op_e             d_op,
    input  logic [mem_pkg::word_len-1:0] wdata,
    output logic [mem_pkg::word_len-1:0] rdata
);
    import mem_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    lane_if lanes [lane_count] ();                     // one bundle per byte lane.

    // address split and store rotation.
    store_splitter splitter_i (
        .clk    (clk),
        .i_addr (i_addr),
        .d_addr (d_addr),
        .d_op   (d_op),
        .wdata  (wdata),
        .lanes  (lanes)
    );

    // four identical banks so a misaligned word is one access.
    for (genvar g = 0; g < lane_count; g++) begin : g_bank
        byte_bank bank_i (
            .clk  (clk),
            .lane (lanes[g])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read back
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // byte reorder, extension and hold of rdata.
    load_merger merger_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .d_addr (d_addr),
        .d_op   (d_op),
        .lanes  (lanes),
        .rdata  (rdata),
        .inst   (inst)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the unified_mem testbench with verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="Something failed"

verilator --binary --timing --assert -j 0 \
    --top-module unified_mem_tb \
    -f unified_mem.f \
    -o unified_mem_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/unified_mem_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "$fail_msg" "$log"; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"
exit 0

// File: test/unified_mem_tb.sv
`timescale 1ns/1ps

module unified_mem_tb;
    import mem_pkg::*;

    localparam int half_period = 20;                   // 40 ns clock.
    localparam int drain_limit = 16;                   // cycles allowed for the last compare.
    localparam logic [31:0] win_base = 32'(mem_bytes - 32); // window straddles the wrap.

    logic                clk = 1'b0;
    logic                rst_n;
    logic [word_len-1:0] i_addr;
    logic [word_len-1:0] inst;
    logic [word_len-1:0] d_addr;
    mem_op_e             d_op;
    logic [word_len-1:0] wdata;
    logic [word_len-1:0] rdata;

    // reference model.
    logic [7:0]          ref_mem [mem_bytes];          // expected memory bytes.
    bit                  written [mem_bytes];          // bytes the test has stored.
    logic [word_len-1:0] held_rdata;                   // rdata after the last load.
    logic [15:0]         lfsr_q;                       // stimulus state.

    // expectations set at the drive edge and staged to the compare edge.
    int                  cur_tag;
    int                  stage_tag;
    int                  done_tag;                     // last access compared.
    logic                cur_chk_i;
    logic                stage_chk_i;
    logic [word_len-1:0] cur_exp_d;
    logic [word_len-1:0] stage_exp_d;
    logic [word_len-1:0] cur_exp_i;
    logic [word_len-1:0] stage_exp_i;

    int                  issued;                       // accesses driven so far.
    int                  mismatches;                   // from the compare process.
    int                  check_errors;                 // from the stimulus process.
    bit                  timed_out;

    always #(half_period) clk = ~clk;

    unified_mem dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_addr (i_addr),
        .inst   (inst),
        .d_addr (d_addr),
        .d_op   (d_op),
        .wdata  (wdata),
        .rdata  (rdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // fibonacci form with taps 16 14 13 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic mem_op_e op_from(input logic [2:0] n);
        mem_op_e op;
        case (n)
            3'd0:    op = op_lb;
            3'd1:    op = op_lh;
            3'd2:    op = op_lw;
            3'd3:    op = op_lbu;
            3'd4:    op = op_lhu;
            3'd5:    op = op_sb;
            3'd6:    op = op_sh;
            default: op = op_sw;
        endcase
        return op;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int access_len(input mem_op_e op);
        int n;
        case (op)
            op_lb, op_lbu, op_sb: n = 1;
            op_lh, op_lhu, op_sh: n = 2;
            op_lw, op_sw:         n = 4;
            default:              n = 0;
        endcase
        return n;
    endfunction

    // byte k of an access wrapped to the memory size.
    function automatic int byte_index(input logic [31:0] addr, input int k);
        logic [31:0] sum;
        sum = addr + 32'(k);
        return int'(sum % 32'(mem_bytes));
    endfunction

    function automatic void apply_store(input logic [31:0] addr, input mem_op_e op,
                                        input logic [31:0] data);
        int idx;
        for (int k = 0; k < access_len(op); k++) begin
            idx          = byte_index(addr, k);
            ref_mem[idx] = data[8*k +: 8];             // little endian.
            written[idx] = 1'b1;
        end
    endfunction

    // n bytes in address order with the low byte first.
    function automatic logic [31:0] gather(input logic [31:0] addr, input int n);
        logic [31:0] word;
        int          idx;
        word = '0;
        for (int k = 0; k < n; k++) begin
            idx = byte_index(addr, k);
            if (!written[idx]) begin
                check_errors++;
                $display("error at %0t: test reads byte %0d that it never wrote", $time, idx);
            end
            word[8*k +: 8] = ref_mem[idx];
        end
        return word;
    endfunction

    function automatic logic [31:0] ref_load(input logic [31:0] addr, input mem_op_e op);
        logic [31:0] word;
        logic [31:0] value;
        word = gather(addr, access_len(op));
        case (op)
            op_lb:   value = {{24{word[7]}}, word[7:0]};
            op_lbu:  value = {24'h0, word[7:0]};
            op_lh:   value = {{16{word[15]}}, word[15:0]};
            op_lhu:  value = {16'h0, word[15:0]};
            default: value = word;
        endcase
        return value;
    endfunction

    function automatic logic [31:0] expect_fetch(input logic [31:0] addr);
        return gather(addr & 32'hffff_fffc, 4);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drive tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic issue(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data,
                         input bit fetch_on, input logic [31:0] faddr);
        logic [31:0] fetch_word;
        fetch_word = '0;
        @(posedge clk);
        if (fetch_on) begin
            fetch_word = expect_fetch(faddr);          // banks read the old bytes.
            i_addr    <= faddr;
        end
        if (op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu}) begin
            held_rdata = ref_load(addr, op);
        end
        if (op inside {op_sb, op_sh, op_sw}) begin
            apply_store(addr, op, data);               // lands at the next edge.
        end
        d_op      <= op;
        d_addr    <= addr;
        wdata     <= data;
        issued++;
        cur_tag   <= issued;
        cur_exp_d <= held_rdata;                       // stores and idle keep it.
        cur_exp_i <= fetch_word;
        cur_chk_i <= fetch_on;
    endtask

    task automatic data_op(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
        issue(op, addr, data, 1'b0, '0);
    endtask

    task automatic read_around(input logic [31:0] base);
        data_op(op_lw, base - 32'd4, '0);
        data_op(op_lw, base, '0);
        data_op(op_lw, base + 32'd4, '0);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        data_op(op_none, '0, '0);
        while (done_tag != issued && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (done_tag != issued) begin
            timed_out = 1'b1;
            $display("error at %0t: compare process stuck at access %0d of %0d",
                     $time, done_tag, issued);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare process
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        stage_tag   <= cur_tag;                        // access the dut just sampled.
        stage_chk_i <= cur_chk_i;
        stage_exp_d <= cur_exp_d;
        stage_exp_i <= cur_exp_i;
    end

    // mid cycle compare of the staged access.
    always @(negedge clk) begin
        if (rst_n && stage_tag != done_tag) begin
            done_tag = stage_tag;
            if (rdata !== stage_exp_d) begin
                mismatches++;
                $display("mismatch at %0t: rdata got %h expected %h", $time, rdata, stage_exp_d);
            end
            if (stage_chk_i && inst !== stage_exp_i) begin
                mismatches++;
                $display("mismatch at %0t: inst got %h expected %h", $time, inst, stage_exp_i);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] a;
        logic [31:0] e;
        logic [31:0] d;
        logic [31:0] f;
        int          off;
        mem_op_e     op;

        rst_n      = 1'b0;
        i_addr     = '0;
        d_addr     = '0;
        d_op       = op_none;
        wdata      = '0;
        lfsr_q     = 16'd92;                           // seed.
        held_rdata = '0;                               // rdata after reset.
        cur_tag    = 0;
        cur_chk_i  = 1'b0;
        cur_exp_d  = '0;
        cur_exp_i  = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // reset values and a few idle cycles.
        @(negedge clk);
        if (rdata !== '0) begin
            check_errors++;
            $display("mismatch at %0t: rdata got %h expected %h", $time, rdata, 32'h0);
        end
        if (inst !== '0) begin
            check_errors++;
            $display("mismatch at %0t: inst got %h expected %h", $time, inst, 32'h0);
        end
        repeat (3) data_op(op_none, '0, '0);

        // aligned words read on both ports and held over an idle cycle.
        repeat (8) begin
            a = take_bits(32) & 32'hffff_fffc;         // upper bits wrap away.
            d = take_bits(32);
            data_op(op_sw, a, d);
            issue(op_lw, a, '0, 1'b1, a);
            data_op(op_none, '0, '0);
        end

        // misaligned loads across rows starting at the last row.
        for (int r = 0; r < 2; r++) begin
            e = (r == 0) ? 32'(mem_bytes - 4) : (take_bits(12) << 2);
            data_op(op_sw, e, take_bits(32));
            data_op(op_sw, e + 32'd4, take_bits(32));
            for (int o = 1; o < 4; o++) begin
                data_op(op_lw, e + 32'(o), '0);
                data_op(op_lh, e + 32'(o), '0);
            end
        end

        // sub-word stores leave the neighbors alone.
        e = take_bits(12) << 2;
        data_op(op_sw, e - 32'd4, take_bits(32));
        data_op(op_sw, e, take_bits(32));
        data_op(op_sw, e + 32'd4, take_bits(32));
        for (int o = 0; o < 4; o++) begin
            data_op(op_sb, e + 32'(o), take_bits(32));
            read_around(e);
            data_op(op_sh, e + 32'(o), take_bits(32));
            read_around(e);
        end

        // sign and zero extension with the top bit clear and set.
        e = take_bits(12) << 2;
        for (int o = 0; o < 4; o++) begin
            for (int top = 0; top < 2; top++) begin
                d     = take_bits(32);
                d[7]  = top[0];                        // byte sign bit.
                d[15] = top[0];                        // halfword sign bit.
                data_op(op_sb, e + 32'(o), d);
                data_op(op_lb, e + 32'(o), '0);
                data_op(op_lbu, e + 32'(o), '0);
                data_op(op_sh, e + 32'(o), d);
                data_op(op_lh, e + 32'(o), '0);
                data_op(op_lhu, e + 32'(o), '0);
            end
        end

        // back to back random traffic in a window across the wrap.
        for (int i = 0; i < 16; i++) begin
            data_op(op_sw, win_base + 32'(4*i), take_bits(32));
        end
        repeat (200) begin
            op  = op_from(3'(take_bits(3)));
            off = int'(take_bits(6));
            if (off > 60) begin
                off = off - 4;                         // whole access inside the window.
            end
            a = win_base + 32'(off);
            d = take_bits(32);
            f = win_base + (take_bits(4) << 2);
            issue(op, a, d, 1'b1, f);
            if (op inside {op_sb, op_sh, op_sw}) begin
                op = op_from(3'(take_bits(2)));        // load the bytes just stored.
                f  = win_base + (take_bits(4) << 2);
                issue(op, a, '0, 1'b1, f);
            end
        end

        drain();
        $display("accesses %0d, mismatches %0d, other errors %0d, timeouts %0d",
                 issued, mismatches, check_errors, timed_out);
        if (mismatches == 0 && check_errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: unified_mem.f
hdl/mem_pkg.sv
hdl/lane_if.sv
hdl/store_splitter.sv
hdl/byte_bank.sv
hdl/load_merger.sv
hdl/unified_mem.sv
test/unified_mem_tb.sv
